// ==== Makefile ====
TOP := ghash_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f flist.f

obj_dir/V$(TOP): flist.f hw/*.sv verification/*.sv
	verilator --binary --timing --assert --top-module $(TOP) -f flist.f

sim: obj_dir/V$(TOP)
	-./obj_dir/V$(TOP) > sim.log 2>&1
	cat sim.log
	! grep -q "Regression failed" sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== flist.f ====
hw/ghash_pkg.sv
hw/ghash_block_intake.sv
hw/ghash_gf_mult.sv
hw/ghash_accumulator.sv
hw/ghash_control_unit.sv
hw/ghash_tag_out.sv
hw/ghash_top.sv
verification/ghash_chk.sv
verification/ghash_tb.sv

// ==== hw/ghash_accumulator.sv ====
`timescale 1ns/1ps

module ghash_accumulator (
    input  logic                        i_clock,
    input  logic                        i_reset,
    input  logic                        i_blk_valid,
    input  logic                        i_hash_done,
    input  logic [ghash_pkg::BLOCK_W-1:0] i_blk_data,
    input  logic [ghash_pkg::BLOCK_W-1:0] i_hash_key,
    output logic [ghash_pkg::BLOCK_W-1:0] o_y
);
    import ghash_pkg::*;

    // Multiplier operand, Y xor X
    logic [BLOCK_W-1:0] y_xor_blk;
    // Next Y on a block strobe
    logic [BLOCK_W-1:0] y_next;

    assign y_xor_blk = o_y ^ i_blk_data;

    // Single-cycle field multiply by H
    ghash_gf_mult gf_mult_i (
        .i_a       (y_xor_blk),
        .i_b       (i_hash_key),
        .o_product (y_next)
    );

    // Running hash state
    // Hold keeps blocks away while hash done is high,
    // so clear and update never collide
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_y <= '0;
        end else if (i_hash_done) begin
            // Fresh start for the next message
            o_y <= '0;
        end else if (i_blk_valid) begin
            o_y <= y_next;
        end
    end

endmodule

// ==== hw/ghash_block_intake.sv ====
`timescale 1ns/1ps

module ghash_block_intake (
    input  logic                        i_clock,
    input  logic                        i_reset,
    input  logic                        i_valid,
    input  logic                        i_skip,
    input  logic                        i_hold,
    input  logic [ghash_pkg::BLOCK_W-1:0] i_block,
    output logic                        o_blk_valid,
    output logic [ghash_pkg::BLOCK_W-1:0] o_blk_data,
    output logic [ghash_pkg::SKIP_W-1:0]  o_skip_count
);
    import ghash_pkg::*;

    // Word goes to the hash only when not skipped and not held off
    logic accept;
    // Skip strobe qualified by the bus valid
    logic skip_word;

    assign accept    = i_valid & ~i_skip & ~i_hold;
    assign skip_word = i_valid & i_skip;

    // One-cycle block strobe
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_blk_valid <= 1'b0;
        end else begin
            o_blk_valid <= accept;
        end
    end

    // Payload register, only loads on accepted words
    always_ff @(posedge i_clock) begin
        if (accept) begin
            o_blk_data <= i_block;
        end
    end

    // Skipped words since reset
    // Counted even while hold is high
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_skip_count <= '0;
        end else if (skip_word) begin
            o_skip_count <= o_skip_count + SKIP_W'(1);
        end
    end

endmodule

// ==== hw/ghash_control_unit.sv ====
`timescale 1ns/1ps

module ghash_control_unit (
    input  logic i_clock,
    input  logic i_reset,
    input  logic i_blk_valid,
    output logic o_hold,
    output logic o_hash_done
);
    import ghash_pkg::*;

    // FSM state
    ghash_state_t state;
    // Blocks counted in the current message
    logic [CNT_W-1:0] blk_cnt;
    // Final block strobe of the message
    logic last_block;
    // Delay chain from final block to hash done
    logic [DONE_STAGES-1:0] done_sr;

    // Count reaches the message length with this strobe
    assign last_block = i_blk_valid && ((blk_cnt + CNT_W'(1)) == CNT_W'(N_BLOCKS));

    // Hold from the final block strobe until hash done retires the message
    assign o_hold = last_block || (state == ST_DRAIN);

    assign o_hash_done = done_sr[DONE_STAGES-1];

    // State and block count
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state   <= ST_IDLE;
            blk_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE, ST_ABSORB: begin
                    if (last_block) begin
                        state <= ST_DRAIN;
                    end else if (i_blk_valid) begin
                        state <= ST_ABSORB;
                    end
                    if (i_blk_valid) begin
                        blk_cnt <= blk_cnt + CNT_W'(1);
                    end
                end
                ST_DRAIN: begin
                    // Tag leaves on this edge
                    if (o_hash_done) begin
                        state   <= ST_IDLE;
                        blk_cnt <= '0;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Last block event delayed into the hash done pulse
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            done_sr <= '0;
        end else begin
            done_sr[0] <= last_block;
            for (int i = 1; i < DONE_STAGES; i++) begin
                done_sr[i] <= done_sr[i-1];
            end
        end
    end

endmodule

// ==== hw/ghash_gf_mult.sv ====
`timescale 1ns/1ps

module ghash_gf_mult (
    input  logic [ghash_pkg::BLOCK_W-1:0] i_a,
    input  logic [ghash_pkg::BLOCK_W-1:0] i_b,
    output logic [ghash_pkg::BLOCK_W-1:0] o_product
);
    import ghash_pkg::*;

    // Shift-and-add in GCM bit order
    // Bit 127 of a vector is the x^0 coefficient
    always_comb begin
        logic [BLOCK_W-1:0] z;
        logic [BLOCK_W-1:0] v;

        z = '0;
        v = i_b;
        for (int i = 0; i < BLOCK_W; i++) begin
            // Walk i_a from x^0 upward, i.e. MSB first
            if (i_a[BLOCK_W-1-i]) begin
                z = z ^ v;
            end
            // Multiply v by x
            // Carry out of x^127 folds back through the polynomial
            if (v[0]) begin
                v = (v >> 1) ^ GF_R;
            end else begin
                v = v >> 1;
            end
        end
        o_product = z;
    end

endmodule

// ==== hw/ghash_pkg.sv ====
package ghash_pkg;

    // Block, key and tag width
    localparam int BLOCK_W = 128;

    // Accepted blocks per message
    localparam int N_BLOCKS = 4;

    // Width of the block counter
    localparam int CNT_W = 16;

    // Width of the skipped word counter
    localparam int SKIP_W = 16;

    // Edges from final block acceptance to tag strobe
    localparam int TAG_DELAY = 3;

    // Stages in the hash done delay chain
    // Intake register and tag register take the other two edges
    localparam int DONE_STAGES = TAG_DELAY - 2;

    // GCM reduction constant, 0xE1 followed by zeros
    localparam logic [BLOCK_W-1:0] GF_R = {8'hE1, {(BLOCK_W-8){1'b0}}};

    // Control FSM states
    typedef enum logic [1:0] {
        // No block of the message taken yet
        ST_IDLE,
        // Some blocks taken, final one still to come
        ST_ABSORB,
        // Final block taken, tag on its way out
        ST_DRAIN
    } ghash_state_t;

endpackage

// ==== hw/ghash_tag_out.sv ====
`timescale 1ns/1ps

module ghash_tag_out (
    input  logic                        i_clock,
    input  logic                        i_reset,
    input  logic                        i_hash_done,
    input  logic [ghash_pkg::BLOCK_W-1:0] i_y,
    output logic                        o_tag_valid,
    output logic [ghash_pkg::BLOCK_W-1:0] o_tag
);
    import ghash_pkg::*;

    // Tag strobe, one cycle after hash done
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_tag_valid <= 1'b0;
        end else begin
            o_tag_valid <= i_hash_done;
        end
    end

    // Tag register
    // Final Y is valid while hash done is high, kept until the next message
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_tag <= {BLOCK_W{1'b0}};
        end else if (i_hash_done) begin
            o_tag <= i_y;
        end
    end

endmodule

// ==== hw/ghash_top.sv ====
`timescale 1ns/1ps

module ghash_top (
    input  logic                        i_clock,
    input  logic                        i_reset,
    input  logic                        i_valid,
    input  logic                        i_skip,
    input  logic [ghash_pkg::BLOCK_W-1:0] i_block,
    input  logic [ghash_pkg::BLOCK_W-1:0] i_hash_key,
    output logic                        o_hold,
    output logic                        o_tag_valid,
    output logic [ghash_pkg::BLOCK_W-1:0] o_tag,
    output logic [ghash_pkg::SKIP_W-1:0]  o_skip_count
);
    import ghash_pkg::*;

    // Accepted block strobe and payload
    logic               blk_valid;
    logic [BLOCK_W-1:0] blk_data;
    // Message finished, Y is final
    logic               hash_done;
    // Running hash
    logic [BLOCK_W-1:0] y_acc;

    ghash_block_intake intake_i (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_valid      (i_valid),
        .i_skip       (i_skip),
        .i_hold       (o_hold),
        .i_block      (i_block),
        .o_blk_valid  (blk_valid),
        .o_blk_data   (blk_data),
        .o_skip_count (o_skip_count)
    );

    ghash_control_unit control_i (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_blk_valid (blk_valid),
        .o_hold      (o_hold),
        .o_hash_done (hash_done)
    );

    ghash_accumulator accum_i (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_blk_valid (blk_valid),
        .i_hash_done (hash_done),
        .i_blk_data  (blk_data),
        .i_hash_key  (i_hash_key),
        .o_y         (y_acc)
    );

    ghash_tag_out tag_out_i (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_hash_done (hash_done),
        .i_y         (y_acc),
        .o_tag_valid (o_tag_valid),
        .o_tag       (o_tag)
    );

endmodule

// ==== verification/ghash_chk.sv ====
`timescale 1ns/1ps

module ghash_chk (
    input logic i_clock,
    input logic i_reset,
    input logic i_hold,
    input logic i_tag_valid
);

    // Tag strobe is a single-cycle pulse
    a_tag_pulse: assert property (
        @(posedge i_clock) disable iff (i_reset)
        i_tag_valid |=> !i_tag_valid
    ) else $error("tag strobe lasted more than one cycle");

    // Strobe only where hold falls
    // Both move on the same edge
    a_tag_hold: assert property (
        @(posedge i_clock) disable iff (i_reset)
        i_tag_valid |-> $fell(i_hold)
    ) else $error("tag strobe without hold falling");

    // Reset releases hold
    a_hold_reset: assert property (
        @(posedge i_clock)
        i_reset |=> !i_hold
    ) else $error("hold high after reset");

endmodule

bind ghash_top ghash_chk chk_i (
    .i_clock     (i_clock),
    .i_reset     (i_reset),
    .i_hold      (o_hold),
    .i_tag_valid (o_tag_valid)
);

// ==== verification/ghash_tb.sv ====
`timescale 1ns/1ps

module ghash_tb;
    import ghash_pkg::*;

    localparam int CLK_PERIOD = 40;
    // Watchdog budget per test
    localparam int CYCLES_PER_TEST = 200;

    logic               i_clock;
    logic               i_reset;
    logic               i_valid;
    logic               i_skip;
    logic [BLOCK_W-1:0] i_block;
    logic [BLOCK_W-1:0] i_hash_key;
    logic               o_hold;
    logic               o_tag_valid;
    logic [BLOCK_W-1:0] o_tag;
    logic [SKIP_W-1:0]  o_skip_count;

    // One entry per test record
    string              t_name[$];
    logic [BLOCK_W-1:0] t_key[$];
    logic [BLOCK_W-1:0] t_tag[$];
    logic [SKIP_W-1:0]  t_skips[$];
    int                 t_nwords[$];
    // Bus words of all tests in file order
    logic               w_skip[$];
    logic [BLOCK_W-1:0] w_data[$];

    logic [31:0] lfsr;
    int          fd;
    int          wi;
    bit          loaded;

    ghash_top dut_i (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_valid      (i_valid),
        .i_skip       (i_skip),
        .i_block      (i_block),
        .i_hash_key   (i_hash_key),
        .o_hold       (o_hold),
        .o_tag_valid  (o_tag_valid),
        .o_tag        (o_tag),
        .o_skip_count (o_skip_count)
    );

    initial begin
        i_clock = 1'b0;
        forever #(CLK_PERIOD / 2) i_clock = ~i_clock;
    end

    // Galois step, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // Idle cycles before a word, 0 to 3
    task automatic random_gap(output int n);
        n = 0;
        for (int b = 0; b < 2; b++) begin
            n = n | (int'(lfsr[0]) << b);
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_tag(input string name, input logic [BLOCK_W-1:0] exp,
                             input logic [BLOCK_W-1:0] act);
        if (act !== exp) begin
            stop_run($sformatf("ERR %s tag expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_skip(input string name, input logic [SKIP_W-1:0] exp,
                              input logic [SKIP_W-1:0] act);
        if (act !== exp) begin
            stop_run($sformatf("ERR %s skip count expected %0d actual %0d", name, exp, act));
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int act);
        if (act != exp) begin
            stop_run($sformatf("ERR %s tag latency expected %0d actual %0d", name, exp, act));
        end
    endtask

    // Next line with data, comment and blank lines skipped
    task automatic read_line(output string line, output bit ok);
        int rc;
        ok = 1'b0;
        while (!ok && !$feof(fd)) begin
            rc = $fgets(line, fd);
            if (rc > 0 && line.getc(0) != "#" && line.getc(0) != "\n") begin
                ok = 1'b1;
            end
        end
    endtask

    task automatic load_tests();
        string              line;
        string              name;
        bit                 ok;
        int                 n;
        int                 sk;
        int                 rc;
        logic [BLOCK_W-1:0] key;
        logic [BLOCK_W-1:0] v;
        logic [SKIP_W-1:0]  cnt;
        fd = $fopen("verification/ghash_tests.dat", "r");
        if (fd == 0) begin
            stop_run("cannot open verification/ghash_tests.dat");
        end
        read_line(line, ok);
        while (ok) begin
            // Header: name, H, word count
            rc = $sscanf(line, "%s %h %d", name, key, n);
            if (rc != 3) begin
                stop_run({"malformed test header: ", line});
            end
            t_name.push_back(name);
            t_key.push_back(key);
            t_nwords.push_back(n);
            for (int i = 0; i < n; i++) begin
                read_line(line, ok);
                rc = $sscanf(line, "%d %h", sk, v);
                if (!ok || rc != 2) begin
                    stop_run({"missing or malformed word line in test ", name});
                end
                w_skip.push_back(sk != 0);
                w_data.push_back(v);
            end
            read_line(line, ok);
            rc = $sscanf(line, "%h %h", v, cnt);
            if (!ok || rc != 2) begin
                stop_run({"missing expected values in test ", name});
            end
            t_tag.push_back(v);
            t_skips.push_back(cnt);
            read_line(line, ok);
        end
        $fclose(fd);
    endtask

    task automatic drive_idle();
        @(posedge i_clock);
        #2;
        i_valid = 1'b0;
        i_skip  = 1'b0;
    endtask

    task automatic drive_word(input logic skip, input logic [BLOCK_W-1:0] word);
        @(posedge i_clock);
        #2;
        i_valid = 1'b1;
        i_skip  = skip;
        i_block = word;
    endtask

    // One message: words with random gaps, then tag timing and values
    task automatic run_test(input int t, inout int idx);
        int gap;
        int edges;
        int n_acc;
        n_acc = 0;
        for (int i = 0; i < t_nwords[t]; i++) begin
            n_acc += w_skip[idx+i] ? 0 : 1;
        end
        // Timing is measured from the last word, which must be a block
        if (n_acc != N_BLOCKS || w_skip[idx+t_nwords[t]-1]) begin
            stop_run({"test ", t_name[t], " does not end with block number N_BLOCKS"});
        end
        // Key for this message, set up ahead of its first word
        @(posedge i_clock);
        #2;
        i_hash_key = t_key[t];
        for (int i = 0; i < t_nwords[t]; i++) begin
            random_gap(gap);
            repeat (gap) drive_idle();
            drive_word(w_skip[idx+i], w_data[idx+i]);
        end
        // Final block taken on this edge
        drive_idle();
        edges = 0;
        do begin
            @(negedge i_clock);
            edges++;
            if (!o_tag_valid && !o_hold) begin
                stop_run({"hold dropped before the tag strobe in test ", t_name[t]});
            end
        end while (!o_tag_valid && edges < 4 * TAG_DELAY);
        if (!o_tag_valid) begin
            stop_run({"no tag strobe after the final block of test ", t_name[t]});
        end
        if (o_hold) begin
            stop_run({"hold still high during the tag strobe in test ", t_name[t]});
        end
        check_latency(t_name[t], TAG_DELAY, edges);
        check_tag(t_name[t], t_tag[t], o_tag);
        check_skip(t_name[t], t_skips[t], o_skip_count);
        idx += t_nwords[t];
    endtask

    initial begin
        i_reset    = 1'b1;
        i_valid    = 1'b0;
        i_skip     = 1'b0;
        i_block    = '0;
        i_hash_key = '0;
        lfsr       = 32'h4089;
        wi         = 0;
        load_tests();
        loaded = 1'b1;
        repeat (3) @(posedge i_clock);
        #2;
        i_reset = 1'b0;
        @(negedge i_clock);
        if (o_hold || o_tag_valid) begin
            stop_run("hold or tag strobe high right after reset");
        end
        foreach (t_name[t]) begin
            run_test(t, wi);
        end
        $display("Regression passed");
        $finish;
    end

    // Watchdog, sized once the test count is known
    initial begin
        wait (loaded);
        #(CLK_PERIOD * (CYCLES_PER_TEST * t_name.size() + 50));
        stop_run("watchdog expired before all tests finished");
    end

endmodule

// ==== verification/ghash_tests.dat ====
# Record: name H word_count, then word_count lines of skip_flag word
# Record end: expected tag and cumulative skip count, all values hex
nist_tc3 b83b533708bf535d0aa6e52980d53b78 4
0 42831ec2217774244b7221b784d0d49c
0 e3aa212f2c02a4e035c17e2329aca12e
0 21d514b25466931c7d8f6a5aac84aa05
0 1ba30b396a0aac973d58e091473f5985
4796cf49464704b5dd91f159bb1b7f95 0000
unit_key_xor 80000000000000000000000000000000 4
0 0123456789abcdef0011223344556677
0 00000000ffffffff00000000ffffffff
0 11111111222222223333333344444444
0 80000000000000000000000000000001
903254765476103233221100ffeeddcd 0000
nist_tc3_skips b83b533708bf535d0aa6e52980d53b78 6
0 42831ec2217774244b7221b784d0d49c
1 deadbeefdeadbeefdeadbeefdeadbeef
0 e3aa212f2c02a4e035c17e2329aca12e
1 ffffffffffffffffffffffffffffffff
0 21d514b25466931c7d8f6a5aac84aa05
0 1ba30b396a0aac973d58e091473f5985
4796cf49464704b5dd91f159bb1b7f95 0002
